// File: hdl/cache_bank_pkg.sv
package cache_bank_pkg;

    localparam int ADDR_WIDTH  = 16;
    localparam int DATA_WIDTH  = 32;
    localparam int NUM_SET     = 64;
    localparam int INDEX_WIDTH = $clog2(NUM_SET);
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH;

    // One word address, read flat or split into tag and set index
    typedef union packed {
        logic [ADDR_WIDTH-1:0] word;
        struct packed {
            logic [TAG_WIDTH-1:0]   tag;
            logic [INDEX_WIDTH-1:0] index;
        } fields;
    } cache_addr_u;

    // Port index width, at least one bit
    function automatic int port_idx_width(input int num_port);
        return (num_port > 1) ? $clog2(num_port) : 1;
    endfunction

endpackage

// File: hdl/tag_lookup_if.sv
`timescale 1ns/1ps

interface tag_lookup_if
    import cache_bank_pkg::*;
();

    logic [INDEX_WIDTH-1:0] index;
    logic [TAG_WIDTH-1:0]   tag;
    logic                   lookup;
    logic                   fill;
    logic                   fill_dirty;
    logic                   mark_dirty;

    // Lookup results, one cycle after lookup
    logic                   hit;
    logic                   victim_dirty;
    logic [TAG_WIDTH-1:0]   victim_tag;
    // Low while valid bits are being cleared
    logic                   ready;

    modport ctrl (output index, tag, lookup, fill, fill_dirty, mark_dirty,
                  input  hit, victim_dirty, victim_tag, ready);

    modport store (input  index, tag, lookup, fill, fill_dirty, mark_dirty,
                   output hit, victim_dirty, victim_tag, ready);

endinterface

// File: hdl/intra_bank_arbiter.sv
`timescale 1ns/1ps

module intra_bank_arbiter
    import cache_bank_pkg::*;
#(
    parameter int NUM_PORT = 2,
    localparam int PORT_WIDTH = port_idx_width(NUM_PORT)
)
(
    input  logic                                 clk_in,
    input  logic                                 reset,

    input  logic [NUM_PORT-1:0]                  req_valid,
    input  logic [NUM_PORT-1:0]                  req_critical,
    input  logic [NUM_PORT-1:0][ADDR_WIDTH-1:0]  req_addr,
    input  logic [NUM_PORT-1:0]                  req_write,
    input  logic [NUM_PORT-1:0][DATA_WIDTH-1:0]  req_wdata,
    output logic [NUM_PORT-1:0]                  issue_ack,

    output logic                                 grant_valid,
    output logic [PORT_WIDTH-1:0]                grant_port,
    output cache_addr_u                          grant_addr,
    output logic                                 grant_write,
    output logic [DATA_WIDTH-1:0]                grant_wdata,
    input  logic                                 take
);

    logic crit_found;

    // Critical class first, lowest index wins inside a class
    always_comb
    begin
        crit_found = 1'b0;
        grant_port = '0;
        for (int i = NUM_PORT - 1; i >= 0; i--)
        begin
            if (req_valid[i] && req_critical[i])
            begin
                grant_port = PORT_WIDTH'(i);
                crit_found = 1'b1;
            end
        end
        if (!crit_found)
        begin
            for (int i = NUM_PORT - 1; i >= 0; i--)
            begin
                if (req_valid[i])
                    grant_port = PORT_WIDTH'(i);
            end
        end
    end

    assign grant_valid     = |req_valid;
    assign grant_addr.word = req_addr[grant_port];
    assign grant_write     = req_write[grant_port];
    assign grant_wdata     = req_wdata[grant_port];

    assign issue_ack = take ? (NUM_PORT'(1) << grant_port) : '0;

    // Only ever ack a single requester that is actually asking
    assert property (@(posedge clk_in) disable iff (reset)
        $onehot0(issue_ack) && ((issue_ack & ~req_valid) == '0));

endmodule

// File: hdl/tag_store.sv
`timescale 1ns/1ps

module tag_store
    import cache_bank_pkg::*;
(
    input  logic         clk_in,
    input  logic         reset,
    tag_lookup_if.store  tags
);

    logic [TAG_WIDTH-1:0]   tag_mem [NUM_SET];
    logic [NUM_SET-1:0]     valid_bits;
    logic [NUM_SET-1:0]     dirty_bits;

    logic                   clearing;
    logic [INDEX_WIDTH-1:0] clear_ptr;

    //////////////////////////////////////////////////
    // Valid clear walk after reset
    //////////////////////////////////////////////////

    always_ff @(posedge clk_in)
    begin
        if (reset)
        begin
            clearing  <= 1'b1;
            clear_ptr <= '0;
        end
        else if (clearing)
        begin
            clear_ptr <= clear_ptr + 1'b1;
            if (clear_ptr == INDEX_WIDTH'(NUM_SET - 1))
                clearing <= 1'b0;
        end
    end

    assign tags.ready = ~clearing;

    always_ff @(posedge clk_in)
    begin
        if (clearing)
            valid_bits[clear_ptr] <= 1'b0;
        else if (tags.fill)
            valid_bits[tags.index] <= 1'b1;
    end

    //////////////////////////////////////////////////
    // Tag and dirty update, registered lookup
    //////////////////////////////////////////////////

    always_ff @(posedge clk_in)
    begin
        if (tags.fill)
        begin
            tag_mem[tags.index]    <= tags.tag;
            dirty_bits[tags.index] <= tags.fill_dirty;
        end
        else if (tags.mark_dirty)
            dirty_bits[tags.index] <= 1'b1;

        if (tags.lookup)
        begin
            tags.hit          <= valid_bits[tags.index] && (tag_mem[tags.index] == tags.tag);
            tags.victim_dirty <= valid_bits[tags.index] && dirty_bits[tags.index];
            tags.victim_tag   <= tag_mem[tags.index];
        end
    end

    // Controller never fills and marks in the same cycle
    assert property (@(posedge clk_in) disable iff (reset)
        !(tags.fill && tags.mark_dirty) && !(tags.lookup && clearing));

endmodule

// File: hdl/data_store.sv
`timescale 1ns/1ps

module data_store
    import cache_bank_pkg::*;
(
    input  logic                   clk_in,
    input  logic [INDEX_WIDTH-1:0] index,
    input  logic                   read_en,
    input  logic                   write_en,
    input  logic [DATA_WIDTH-1:0]  write_data,
    output logic [DATA_WIDTH-1:0]  read_data
);

    logic [DATA_WIDTH-1:0] mem [NUM_SET];

    always_ff @(posedge clk_in)
    begin
        if (write_en)
            mem[index] <= write_data;
    end

    // Read word holds until the next read enable
    always_ff @(posedge clk_in)
    begin
        if (read_en)
            read_data <= mem[index];
    end

endmodule

// File: hdl/bank_ctrl.sv
`timescale 1ns/1ps

module bank_ctrl
    import cache_bank_pkg::*;
#(
    parameter int NUM_PORT = 2,
    localparam int PORT_WIDTH = port_idx_width(NUM_PORT)
)
(
    input  logic                   clk_in,
    input  logic                   reset,

    input  logic                   grant_valid,
    input  logic [PORT_WIDTH-1:0]  grant_port,
    input  cache_addr_u            grant_addr,
    input  logic                   grant_write,
    input  logic [DATA_WIDTH-1:0]  grant_wdata,
    output logic                   take,

    output logic                   miss_valid,
    output cache_addr_u            miss_addr,
    input  logic                   miss_ack,
    input  logic                   fetched_valid,
    input  logic [DATA_WIDTH-1:0]  fetched_data,
    output logic                   fetch_ack,

    output logic                   wb_valid,
    output cache_addr_u            wb_addr,
    output logic [DATA_WIDTH-1:0]  wb_data,
    input  logic                   wb_ack,

    output logic                   return_valid,
    output logic [DATA_WIDTH-1:0]  return_data,
    output logic [PORT_WIDTH-1:0]  return_port,
    input  logic                   return_ack,

    output logic [INDEX_WIDTH-1:0] data_index,
    output logic                   data_read_en,
    output logic                   data_write_en,
    output logic [DATA_WIDTH-1:0]  data_write_data,
    input  logic [DATA_WIDTH-1:0]  data_read,

    tag_lookup_if.ctrl             tags
);

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_LOOKUP    = 3'd1;
    localparam logic [2:0] S_READ      = 3'd2;
    localparam logic [2:0] S_WRITEBACK = 3'd3;
    localparam logic [2:0] S_MISS      = 3'd4;
    localparam logic [2:0] S_WAIT_FILL = 3'd5;
    localparam logic [2:0] S_RETURN    = 3'd6;

    logic [2:0]            state;
    logic [PORT_WIDTH-1:0] req_port;
    cache_addr_u           req_addr;
    logic                  req_write;
    logic [DATA_WIDTH-1:0] req_wdata;
    logic [DATA_WIDTH-1:0] return_hold;
    logic [DATA_WIDTH-1:0] hit_word;
    logic [DATA_WIDTH-1:0] fill_word;

    assign take      = (state == S_IDLE) && grant_valid && tags.ready;
    assign hit_word  = req_write ? req_wdata : data_read;
    assign fill_word = req_write ? req_wdata : fetched_data;

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk_in)
    begin
        if (reset)
            state <= S_IDLE;
        else
        begin
            case (state)
                S_IDLE:      if (take) state <= S_LOOKUP;
                S_LOOKUP:    state <= S_READ;
                S_READ:
                begin
                    if (tags.hit)
                        state <= return_ack ? S_IDLE : S_RETURN;
                    else
                        state <= tags.victim_dirty ? S_WRITEBACK : S_MISS;
                end
                S_WRITEBACK: if (wb_ack) state <= S_MISS;
                S_MISS:      if (miss_ack) state <= S_WAIT_FILL;
                S_WAIT_FILL: if (fetched_valid) state <= S_RETURN;
                S_RETURN:    if (return_ack) state <= S_IDLE;
                default:     state <= S_IDLE;
            endcase
        end
    end

    // Request and return payload
    always_ff @(posedge clk_in)
    begin
        if (take)
        begin
            req_port  <= grant_port;
            req_addr  <= grant_addr;
            req_write <= grant_write;
            req_wdata <= grant_wdata;
        end
        if (state == S_READ)
            return_hold <= hit_word;
        else if ((state == S_WAIT_FILL) && fetched_valid)
            return_hold <= fill_word;
    end

    //////////////////////////////////////////////////
    // Tag and data store control
    //////////////////////////////////////////////////

    assign tags.index      = req_addr.fields.index;
    assign tags.tag        = req_addr.fields.tag;
    assign tags.lookup     = (state == S_LOOKUP);
    assign tags.fill       = (state == S_WAIT_FILL) && fetched_valid;
    assign tags.fill_dirty = req_write;
    assign tags.mark_dirty = (state == S_READ) && tags.hit && req_write;

    // Hit word and victim word share the set, so one read serves both
    assign data_index      = req_addr.fields.index;
    assign data_read_en    = (state == S_LOOKUP);
    assign data_write_en   = tags.mark_dirty || tags.fill;
    assign data_write_data = (state == S_WAIT_FILL) ? fill_word : req_wdata;

    assign wb_valid  = (state == S_WRITEBACK);
    assign wb_addr   = {tags.victim_tag, req_addr.fields.index};
    assign wb_data   = data_read;

    assign miss_valid = (state == S_MISS);
    assign miss_addr  = req_addr;
    assign fetch_ack  = tags.fill;

    assign return_valid = ((state == S_READ) && tags.hit) || (state == S_RETURN);
    assign return_data  = (state == S_READ) ? hit_word : return_hold;
    assign return_port  = req_port;

    // Writeback and miss requests hold until acked and never overlap
    assert property (@(posedge clk_in) disable iff (reset)
        wb_valid && !wb_ack |=>
            wb_valid && !miss_valid && $stable(wb_addr) && $stable(wb_data));

    assert property (@(posedge clk_in) disable iff (reset)
        miss_valid && !miss_ack |=>
            miss_valid && !wb_valid && $stable(miss_addr));

    assert property (@(posedge clk_in) disable iff (reset)
        return_valid && !return_ack |=>
            return_valid && $stable(return_data) && $stable(return_port));

endmodule

// File: hdl/unified_cache_bank.sv
`timescale 1ns/1ps

module unified_cache_bank
    import cache_bank_pkg::*;
#(
    parameter int NUM_PORT = 2,
    localparam int PORT_WIDTH = port_idx_width(NUM_PORT)
)
(
    input  logic                                 clk_in,
    input  logic                                 reset,

    input  logic [NUM_PORT-1:0][ADDR_WIDTH-1:0]  req_addr,
    input  logic [NUM_PORT-1:0]                  req_write,
    input  logic [NUM_PORT-1:0][DATA_WIDTH-1:0]  req_wdata,
    input  logic [NUM_PORT-1:0]                  req_valid,
    input  logic [NUM_PORT-1:0]                  req_critical,
    output logic [NUM_PORT-1:0]                  issue_ack,

    output logic                                 miss_valid,
    output cache_addr_u                          miss_addr,
    input  logic                                 miss_ack,
    input  logic                                 fetched_valid,
    input  logic [DATA_WIDTH-1:0]                fetched_data,
    output logic                                 fetch_ack,

    output logic                                 wb_valid,
    output cache_addr_u                          wb_addr,
    output logic [DATA_WIDTH-1:0]                wb_data,
    input  logic                                 wb_ack,

    output logic                                 return_valid,
    output logic [DATA_WIDTH-1:0]                return_data,
    output logic [PORT_WIDTH-1:0]                return_port,
    input  logic                                 return_ack
);

    logic                   grant_valid;
    logic [PORT_WIDTH-1:0]  grant_port;
    cache_addr_u            grant_addr;
    logic                   grant_write;
    logic [DATA_WIDTH-1:0]  grant_wdata;
    logic                   take;

    logic [INDEX_WIDTH-1:0] data_index;
    logic                   data_read_en;
    logic                   data_write_en;
    logic [DATA_WIDTH-1:0]  data_write_data;
    logic [DATA_WIDTH-1:0]  data_read;

    tag_lookup_if tags ();

    intra_bank_arbiter #(.NUM_PORT(NUM_PORT)) arbiter (
        .clk_in       (clk_in),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_critical (req_critical),
        .req_addr     (req_addr),
        .req_write    (req_write),
        .req_wdata    (req_wdata),
        .issue_ack    (issue_ack),
        .grant_valid  (grant_valid),
        .grant_port   (grant_port),
        .grant_addr   (grant_addr),
        .grant_write  (grant_write),
        .grant_wdata  (grant_wdata),
        .take         (take)
    );

    bank_ctrl #(.NUM_PORT(NUM_PORT)) ctrl (
        .clk_in          (clk_in),
        .reset           (reset),
        .grant_valid     (grant_valid),
        .grant_port      (grant_port),
        .grant_addr      (grant_addr),
        .grant_write     (grant_write),
        .grant_wdata     (grant_wdata),
        .take            (take),
        .miss_valid      (miss_valid),
        .miss_addr       (miss_addr),
        .miss_ack        (miss_ack),
        .fetched_valid   (fetched_valid),
        .fetched_data    (fetched_data),
        .fetch_ack       (fetch_ack),
        .wb_valid        (wb_valid),
        .wb_addr         (wb_addr),
        .wb_data         (wb_data),
        .wb_ack          (wb_ack),
        .return_valid    (return_valid),
        .return_data     (return_data),
        .return_port     (return_port),
        .return_ack      (return_ack),
        .data_index      (data_index),
        .data_read_en    (data_read_en),
        .data_write_en   (data_write_en),
        .data_write_data (data_write_data),
        .data_read       (data_read),
        .tags            (tags.ctrl)
    );

    tag_store tag_arrays (
        .clk_in (clk_in),
        .reset  (reset),
        .tags   (tags.store)
    );

    data_store data_array (
        .clk_in     (clk_in),
        .index      (data_index),
        .read_en    (data_read_en),
        .write_en   (data_write_en),
        .write_data (data_write_data),
        .read_data  (data_read)
    );

endmodule

// File: bench/unified_cache_bank_tb.sv
`timescale 1ns/1ps

module unified_cache_bank_tb
    import cache_bank_pkg::*;
();

    localparam int NUM_PORT       = 2;
    localparam int PORT_WIDTH     = port_idx_width(NUM_PORT);
    localparam int NUM_TRANS      = 400;
    localparam int TIMEOUT_CYCLES = NUM_TRANS * 40;

    logic                                clk_in;
    logic                                reset;
    logic [NUM_PORT-1:0][ADDR_WIDTH-1:0] req_addr;
    logic [NUM_PORT-1:0]                 req_write;
    logic [NUM_PORT-1:0][DATA_WIDTH-1:0] req_wdata;
    logic [NUM_PORT-1:0]                 req_valid;
    logic [NUM_PORT-1:0]                 req_critical;
    logic [NUM_PORT-1:0]                 issue_ack;
    logic                                miss_valid;
    cache_addr_u                         miss_addr;
    logic                                miss_ack;
    logic                                fetched_valid;
    logic [DATA_WIDTH-1:0]               fetched_data;
    logic                                fetch_ack;
    logic                                wb_valid;
    cache_addr_u                         wb_addr;
    logic [DATA_WIDTH-1:0]               wb_data;
    logic                                wb_ack;
    logic                                return_valid;
    logic [DATA_WIDTH-1:0]               return_data;
    logic [PORT_WIDTH-1:0]               return_port;
    logic                                return_ack;

    // Backing memory and direct-mapped content model
    logic [DATA_WIDTH-1:0] mem_model [1 << ADDR_WIDTH];
    logic                  model_valid [NUM_SET];
    logic                  model_dirty [NUM_SET];
    logic [TAG_WIDTH-1:0]  model_tag [NUM_SET];
    logic [DATA_WIDTH-1:0] model_data [NUM_SET];

    // Request in flight
    logic                  in_flight;
    logic [PORT_WIDTH-1:0] cur_port;
    cache_addr_u           cur_addr;
    logic                  cur_hit;
    logic                  exp_wb;
    cache_addr_u           exp_wb_addr;
    logic [DATA_WIDTH-1:0] exp_wb_data;
    logic [DATA_WIDTH-1:0] exp_ret;
    logic                  wb_done;
    logic                  fill_done;
    logic                  ret_seen;
    int                    ack_cycle;

    logic [NUM_PORT-1:0]   clear_mask;
    cache_addr_u           fetch_addr;
    int                    fetch_state;
    int                    fetch_delay;
    int                    cycle_count;
    int                    generated;
    int                    done_count;

    unified_cache_bank #(.NUM_PORT(NUM_PORT)) dut (.*);

    initial clk_in = 1'b0;
    always #5 clk_in = ~clk_in;

    //////////////////////////////////////////////////
    // Reporting and compare tasks
    //////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_data(input string name, input logic [DATA_WIDTH-1:0] got,
                                input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic compare_addr(input string name, input cache_addr_u got,
                                input cache_addr_u exp);
        if (got.word !== exp.word)
            abort_run($sformatf("Error at %0t: %s = %h, expected %h", $time, name,
                                got.word, exp.word));
    endtask

    task automatic compare_port(input string name, input logic [PORT_WIDTH-1:0] got,
                                input logic [PORT_WIDTH-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp));
    endtask

    //////////////////////////////////////////////////
    // Stimulus and model
    //////////////////////////////////////////////////

    // Four tags over four sets, so conflicts and evictions are frequent
    function automatic cache_addr_u pick_addr();
        cache_addr_u a;
        a.fields.tag   = TAG_WIDTH'($urandom_range(0, 3));
        a.fields.index = INDEX_WIDTH'($urandom_range(0, 3) * 17);
        return a;
    endfunction

    function automatic logic [PORT_WIDTH-1:0] expected_winner();
        logic [PORT_WIDTH-1:0] w;
        logic                  found;
        w = '0;
        found = 1'b0;
        for (int p = 0; p < NUM_PORT; p++)
        begin
            if (!found && req_valid[p] && req_critical[p])
            begin
                w = PORT_WIDTH'(p);
                found = 1'b1;
            end
        end
        for (int p = 0; p < NUM_PORT; p++)
        begin
            if (!found && req_valid[p])
            begin
                w = PORT_WIDTH'(p);
                found = 1'b1;
            end
        end
        return w;
    endfunction

    task automatic start_model(input logic [PORT_WIDTH-1:0] port);
        cache_addr_u            a;
        logic [INDEX_WIDTH-1:0] idx;
        a.word = req_addr[port];
        idx = a.fields.index;
        cur_port = port;
        cur_addr = a;
        cur_hit = model_valid[idx] && (model_tag[idx] == a.fields.tag);
        exp_wb = !cur_hit && model_valid[idx] && model_dirty[idx];
        exp_wb_addr.fields.tag = model_tag[idx];
        exp_wb_addr.fields.index = idx;
        exp_wb_data = model_data[idx];
        if (req_write[port])
            exp_ret = req_wdata[port];
        else if (cur_hit)
            exp_ret = model_data[idx];
        else
            exp_ret = mem_model[a.word];
        model_dirty[idx] = (cur_hit && model_dirty[idx]) || req_write[port];
        model_valid[idx] = 1'b1;
        model_tag[idx] = a.fields.tag;
        model_data[idx] = exp_ret;
        in_flight = 1'b1;
        ack_cycle = cycle_count;
        {wb_done, fill_done, ret_seen} = 3'b000;
    endtask

    task automatic drive_cycle();
        cache_addr_u new_addr;
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
            abort_run("Timeout: the transactions did not complete within the cycle limit");
        for (int p = 0; p < NUM_PORT; p++)
        begin
            if (clear_mask[p])
                req_valid[p] = 1'b0;
            if (!req_valid[p] && generated < NUM_TRANS && $urandom_range(0, 1) == 0)
            begin
                new_addr = pick_addr();
                req_addr[p] = new_addr.word;
                req_write[p] = ($urandom_range(0, 2) == 0);
                req_wdata[p] = $urandom();
                req_critical[p] = ($urandom_range(0, 3) == 0);
                req_valid[p] = 1'b1;
                generated++;
            end
        end
        clear_mask = '0;
        // Acks are withheld at random to exercise back-pressure
        wb_ack = ($urandom_range(0, 2) != 0);
        miss_ack = ($urandom_range(0, 2) != 0);
        return_ack = ($urandom_range(0, 2) != 0);
        if (fetch_state == 1)
        begin
            if (fetch_delay == 0)
            begin
                fetched_valid = 1'b1;
                fetched_data = mem_model[fetch_addr.word];
                fetch_state = 2;
            end
            else
                fetch_delay--;
        end
        else if (fetch_state == 3)
        begin
            fetched_valid = 1'b0;
            fetch_state = 0;
        end
    endtask

    task automatic check_cycle();
        logic [PORT_WIDTH-1:0] got_port;
        got_port = '0;
        if (issue_ack != '0)
        begin
            if (in_flight)
                abort_run("A second issue_ack came before return_ack of the request in flight");
            if (!$onehot(issue_ack))
                abort_run("issue_ack went to more than one port");
            for (int p = 0; p < NUM_PORT; p++)
                if (issue_ack[p])
                    got_port = PORT_WIDTH'(p);
            compare_port("issue_ack port", got_port, expected_winner());
            start_model(got_port);
            clear_mask[got_port] = 1'b1;
        end
        if (in_flight && cur_hit && !ret_seen && (return_valid != (cycle_count == ack_cycle + 2)))
            abort_run("Hit return_valid did not come exactly 2 cycles after issue_ack");
        if (wb_valid)
        begin
            if (!in_flight || !exp_wb)
                abort_run("wb_valid rose although the victim is not dirty");
            if (miss_valid)
                abort_run("miss_valid and wb_valid are high together");
            compare_addr("wb_addr", wb_addr, exp_wb_addr);
            compare_data("wb_data", wb_data, exp_wb_data);
            if (wb_ack)
            begin
                mem_model[wb_addr.word] = wb_data;
                wb_done = 1'b1;
            end
        end
        if (miss_valid)
        begin
            if (!in_flight || cur_hit)
                abort_run("miss_valid rose on a hit or with no request in flight");
            if (exp_wb && !wb_done)
                abort_run("miss_valid rose before the dirty victim was written back");
            compare_addr("miss_addr", miss_addr, cur_addr);
            if (miss_ack)
            begin
                fetch_addr = miss_addr;
                fetch_delay = $urandom_range(0, 5);
                fetch_state = 1;
            end
        end
        if (fetch_ack && !fetched_valid)
            abort_run("fetch_ack pulsed without fetched_valid");
        if (fetch_ack)
        begin
            fill_done = 1'b1;
            fetch_state = 3;
        end
        if (return_valid)
        begin
            if (!in_flight)
                abort_run("return_valid rose with no request in flight");
            if (!cur_hit && !fill_done)
                abort_run("A miss returned before its fill");
            compare_data("return_data", return_data, exp_ret);
            compare_port("return_port", return_port, cur_port);
            ret_seen = 1'b1;
            if (return_ack)
            begin
                in_flight = 1'b0;
                done_count++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        void'($urandom(96));
        reset = 1'b1;
        {req_addr, req_write, req_wdata, req_valid, req_critical} = '0;
        {miss_ack, fetched_valid, fetched_data, wb_ack, return_ack} = '0;
        {in_flight, clear_mask, fetch_addr} = '0;
        {fetch_state, fetch_delay, cycle_count, generated, done_count, ack_cycle} = '0;
        for (int a = 0; a < (1 << ADDR_WIDTH); a++)
            mem_model[a] = DATA_WIDTH'(a) * 32'h9e37_79b9;
        for (int s = 0; s < NUM_SET; s++)
        begin
            {model_valid[s], model_dirty[s]} = 2'b00;
            model_tag[s] = '0;
            model_data[s] = '0;
        end
        repeat (15) @(posedge clk_in);
        @(negedge clk_in);
        if (issue_ack != '0 || miss_valid || wb_valid || fetch_ack || return_valid)
            abort_run("Handshake outputs are not low during reset");
        @(posedge clk_in);
        #1;
        reset = 1'b0;
        while (done_count < NUM_TRANS)
        begin
            @(posedge clk_in);
            #1;
            drive_cycle();
            @(negedge clk_in);
            check_cycle();
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: build.f
hdl/cache_bank_pkg.sv
hdl/tag_lookup_if.sv
hdl/intra_bank_arbiter.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/bank_ctrl.sv
hdl/unified_cache_bank.sv
bench/unified_cache_bank_tb.sv

// File: Makefile
# Verilator build, run and lint for the unified cache bank

VERILATOR  ?= verilator
TOP        ?= unified_cache_bank_tb
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulation binary is the test result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
